// ==== hdl/mac_pe.sv ====
`default_nettype none
`timescale 1ns/100ps

module mac_pe (
    input  wire                                clk,
    input  wire                                rstn,
    input  wire                                ops_valid,
    input  mc_pkg::pe_operands_t               ops,
    output logic                               ops_ready,
    output logic                               res_valid,
    output logic signed [mc_pkg::PSUM_W-1:0]   res_psum,
    input  wire                                res_ready
);

    import mc_pkg::*;

    logic                     fire;
    logic signed [PSUM_W-1:0] product;
    logic signed [PSUM_W-1:0] psum_next;

    //////////////////////////////
    // Datapath
    //////////////////////////////

    // 16x16 signed product over the full 32 bit range
    assign product   = $signed(ops.ifmap) * $signed(ops.weight);
    // Accumulate with wrap at 32 bits
    assign psum_next = ops.psum + product;

    // Free slot or slot leaving this cycle
    assign ops_ready = !res_valid || res_ready;
    assign fire      = ops_valid && ops_ready;

    //////////////////////////////
    // Result register
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else if (fire) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (fire) begin
            res_psum <= psum_next;
        end
    end

    // Waiting operand set held steady by the multicaster
    a_ops_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (ops_valid && !ops_ready) |=> (ops_valid && $stable(ops))
    );

endmodule

`default_nettype wire

// ==== hdl/mc_pkg.sv ====
`default_nettype none

package mc_pkg;

    //////////////////////////////
    // Row sizing
    //////////////////////////////
    localparam int NUM_PE   = 4;
    localparam int DATA_W   = 16;
    localparam int PSUM_W   = 32;
    // More tag codes than PEs, so a word may hit nobody
    localparam int TAG_W    = 3;
    localparam int PE_IDX_W = 2;

    // Kind of a broadcast word
    typedef enum logic [1:0] {
        KIND_IFMAP = 2'd0,
        KIND_FLTR  = 2'd1,
        KIND_PSUM  = 2'd2
    } op_kind_e;

    // Operand view, low half carries the value
    typedef struct packed {
        logic [PSUM_W-DATA_W-1:0] rsvd;
        logic signed [DATA_W-1:0] val;
    } gb_operand_t;

    // One payload word, read as psum or as operand
    typedef union packed {
        logic signed [PSUM_W-1:0] psum;
        gb_operand_t              op;
    } gb_payload_u;

    // Broadcast bus word
    typedef struct packed {
        op_kind_e          kind;
        logic [TAG_W-1:0]  tag;
        gb_payload_u       payload;
    } gb_word_t;

    // Full operand set handed to a PE
    typedef struct packed {
        logic signed [DATA_W-1:0] ifmap;
        logic signed [DATA_W-1:0] weight;
        logic signed [PSUM_W-1:0] psum;
    } pe_operands_t;

    // Result bus word back to the buffer
    typedef struct packed {
        logic [PE_IDX_W-1:0]      pe_idx;
        logic signed [PSUM_W-1:0] psum;
    } psum_result_t;

endpackage

`default_nettype wire

// ==== hdl/multicaster.sv ====
`default_nettype none
`timescale 1ns/100ps

module multicaster (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         flush,
    input  wire [mc_pkg::TAG_W-1:0]     cfg_tag,
    // Transfer strobe, bus valid and ready together
    input  wire                         gb_valid_xfer,
    input  mc_pkg::gb_word_t            gb_word,
    output logic                        accept,
    output logic                        ops_valid,
    output mc_pkg::pe_operands_t        ops,
    input  wire                         ops_ready
);

    import mc_pkg::*;

    logic [TAG_W-1:0] tag_q;
    logic             match;
    logic             take;
    logic             acc_ifmap, acc_fltr, acc_psum;
    logic             full_ifmap, full_fltr, full_psum;
    gb_payload_u      val_ifmap, val_fltr, val_psum;

    //////////////////////////////
    // Tag register
    //////////////////////////////

    // Loaded on flush, slots untouched
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tag_q <= '0;
        end else if (flush) begin
            tag_q <= cfg_tag;
        end
    end

    // Single compare shared by all three slots
    assign match = (gb_word.tag == tag_q);

    //////////////////////////////
    // Operand slots
    //////////////////////////////

    operand_slot #(.KIND(KIND_IFMAP)) u_slot_ifmap (
        .clk(clk), .rstn(rstn), .word_valid(gb_valid_xfer), .word(gb_word),
        .match(match), .accept(acc_ifmap), .full(full_ifmap), .value(val_ifmap),
        .take(take)
    );

    operand_slot #(.KIND(KIND_FLTR)) u_slot_fltr (
        .clk(clk), .rstn(rstn), .word_valid(gb_valid_xfer), .word(gb_word),
        .match(match), .accept(acc_fltr), .full(full_fltr), .value(val_fltr),
        .take(take)
    );

    operand_slot #(.KIND(KIND_PSUM)) u_slot_psum (
        .clk(clk), .rstn(rstn), .word_valid(gb_valid_xfer), .word(gb_word),
        .match(match), .accept(acc_psum), .full(full_psum), .value(val_psum),
        .take(take)
    );

    assign accept    = acc_ifmap & acc_fltr & acc_psum;
    // PE sees a set only once every kind is present
    assign ops_valid = full_ifmap & full_fltr & full_psum;
    // All three slots drain together
    assign take      = ops_valid & ops_ready;

    // Operand view for ifmap and weight, psum view for the sum
    always_comb begin
        ops.ifmap  = val_ifmap.op.val;
        ops.weight = val_fltr.op.val;
        ops.psum   = val_psum.psum;
    end

    // Buffer retags only while this PE has no complete set waiting
    a_flush_idle: assert property (
        @(posedge clk) disable iff (!rstn)
        flush |-> !ops_valid
    );

endmodule

`default_nettype wire

// ==== hdl/operand_slot.sv ====
`default_nettype none
`timescale 1ns/100ps

module operand_slot #(
    parameter mc_pkg::op_kind_e KIND = mc_pkg::KIND_IFMAP
) (
    input  wire                 clk,
    input  wire                 rstn,
    // Bus valid already qualified by bus ready
    input  wire                 word_valid,
    input  mc_pkg::gb_word_t    word,
    // Tag compare from the multicaster
    input  wire                 match,
    output logic                accept,
    output logic                full,
    output mc_pkg::gb_payload_u value,
    input  wire                 take
);

    logic hit;
    logic load;

    //////////////////////////////
    // Word filter
    //////////////////////////////

    // Word is addressed here and is of this slot's kind
    assign hit  = match && (word.kind == KIND);
    assign load = word_valid && hit;

    // Stall the bus only for our own kind while occupied
    // no bypass on take, keeps ready free of the PE path
    assign accept = !(full && hit);

    //////////////////////////////
    // Holding register
    //////////////////////////////

    // Occupancy flag
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    // Payload, captured whole and decoded by the parent
    always_ff @(posedge clk) begin
        if (load) begin
            value <= word.payload;
        end
    end

    // Top-level ready AND must keep a full slot from being overwritten
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (!rstn)
        load |-> (!full || take)
    );

endmodule

`default_nettype wire

// ==== hdl/pe_row.sv ====
`default_nettype none
`timescale 1ns/100ps

module pe_row (
    input  wire                                          clk,
    input  wire                                          rstn,
    // Configuration
    input  wire                                          flush,
    input  wire  [mc_pkg::NUM_PE-1:0][mc_pkg::TAG_W-1:0]  cfg_tags,
    // Broadcast bus from the global buffer
    input  wire                                          gb_valid,
    input  mc_pkg::gb_word_t                             gb_word,
    output logic                                         gb_ready,
    // Result bus back to the buffer
    output logic                                         res_valid,
    output mc_pkg::psum_result_t                         res_word,
    input  wire                                          res_ready
);

    import mc_pkg::*;

    logic                             gb_xfer;
    logic [NUM_PE-1:0]                accept;
    logic [NUM_PE-1:0]                ops_valid;
    logic [NUM_PE-1:0]                ops_ready;
    pe_operands_t                     ops [NUM_PE];
    logic [NUM_PE-1:0]                pe_res_valid;
    logic [NUM_PE-1:0]                pe_res_ready;
    logic [NUM_PE-1:0][PSUM_W-1:0]    pe_res_psum;

    // Every PE must take or ignore the word
    assign gb_ready = &accept;
    assign gb_xfer  = gb_valid && gb_ready;

    //////////////////////////////
    // Multicaster and PE pairs
    //////////////////////////////
    for (genvar g = 0; g < NUM_PE; g++) begin : g_pe
        multicaster u_mc (
            .clk(clk), .rstn(rstn), .flush(flush), .cfg_tag(cfg_tags[g]),
            .gb_valid_xfer(gb_xfer), .gb_word(gb_word), .accept(accept[g]),
            .ops_valid(ops_valid[g]), .ops(ops[g]), .ops_ready(ops_ready[g])
        );

        mac_pe u_pe (
            .clk(clk), .rstn(rstn), .ops_valid(ops_valid[g]), .ops(ops[g]),
            .ops_ready(ops_ready[g]), .res_valid(pe_res_valid[g]),
            .res_psum(pe_res_psum[g]), .res_ready(pe_res_ready[g])
        );
    end

    // Shared result bus
    psum_arbiter u_arb (
        .clk(clk), .rstn(rstn), .req_valid(pe_res_valid), .req_psum(pe_res_psum),
        .req_ready(pe_res_ready), .res_valid(res_valid), .res_word(res_word),
        .res_ready(res_ready)
    );

endmodule

`default_nettype wire

// ==== hdl/psum_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

module psum_arbiter (
    input  wire                                          clk,
    input  wire                                          rstn,
    input  wire  [mc_pkg::NUM_PE-1:0]                    req_valid,
    input  wire  [mc_pkg::NUM_PE-1:0][mc_pkg::PSUM_W-1:0] req_psum,
    output logic [mc_pkg::NUM_PE-1:0]                    req_ready,
    output logic                                         res_valid,
    output mc_pkg::psum_result_t                         res_word,
    input  wire                                          res_ready
);

    import mc_pkg::*;

    logic [PE_IDX_W-1:0] ptr_q;
    logic [PE_IDX_W-1:0] lock_idx_q;
    logic                locked_q;
    logic [PE_IDX_W-1:0] cand;
    logic [PE_IDX_W-1:0] pick;
    logic                found;
    logic [PE_IDX_W-1:0] grant_idx;

    //////////////////////////////
    // Round-robin pick
    //////////////////////////////

    // Scan from the pointer with the index wrapping at PE_IDX_W
    always_comb begin
        found = 1'b0;
        pick  = ptr_q;
        cand  = ptr_q;
        for (int i = 0; i < NUM_PE; i++) begin
            cand = ptr_q + PE_IDX_W'(i);
            if (!found && req_valid[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    // Stalled grant stays put
    assign grant_idx = locked_q ? lock_idx_q : pick;
    assign res_valid = req_valid[grant_idx];

    // Winner's result forwarded without a register
    always_comb begin
        res_word.pe_idx = grant_idx;
        res_word.psum   = req_psum[grant_idx];
    end

    always_comb begin
        for (int i = 0; i < NUM_PE; i++) begin
            req_ready[i] = res_ready && (grant_idx == PE_IDX_W'(i));
        end
    end

    //////////////////////////////
    // Pointer and lock
    //////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptr_q      <= '0;
            lock_idx_q <= '0;
            locked_q   <= 1'b0;
        end else begin
            locked_q <= res_valid && !res_ready;
            if (res_valid && !res_ready) begin
                lock_idx_q <= grant_idx;
            end
            // Move past the winner once it is taken
            if (res_valid && res_ready) begin
                ptr_q <= grant_idx + 1'b1;
            end
        end
    end

    // Stalled result stays on the bus unchanged
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_word))
    );

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/mc_pkg.sv
hdl/operand_slot.sv
hdl/multicaster.sv
hdl/mac_pe.sv
hdl/psum_arbiter.sv
hdl/pe_row.sv
tests/tb_pe_row.sv

// ==== tests/tb_pe_row.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_pe_row;

    import mc_pkg::*;

    localparam int NUM_XFER  = 400;
    localparam int PHASES    = 4;
    // Watchdog budget per transfer plus slack for drains
    localparam int CYC_LIMIT = NUM_XFER * 12 + 200;

    logic                         clk;
    logic                         rstn;
    logic                         flush;
    logic [NUM_PE-1:0][TAG_W-1:0] cfg_tags;
    logic                         gb_valid;
    gb_word_t                     gb_word;
    logic                         gb_ready;
    logic                         res_valid;
    psum_result_t                 res_word;
    logic                         res_ready;

    integer seed = 83263;
    int     errors;
    int     n_results;
    int     cycles;
    int     stall_left;
    // Reference model state
    int     model_tags [NUM_PE];
    // Held operands per PE, second index is the kind code
    int     op_q [NUM_PE][3][$];
    int     exp_q [NUM_PE][$];

    pe_row i_dut (
        .clk(clk), .rstn(rstn), .flush(flush), .cfg_tags(cfg_tags),
        .gb_valid(gb_valid), .gb_word(gb_word), .gb_ready(gb_ready),
        .res_valid(res_valid), .res_word(res_word), .res_ready(res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // Bus would block forever if a matching PE already holds this kind unfired
    function automatic bit word_safe(input int tag, input int kind);
        for (int p = 0; p < NUM_PE; p++) begin
            if (model_tags[p] == tag && op_q[p][kind].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic bit results_pending();
        for (int p = 0; p < NUM_PE; p++) begin
            if (exp_q[p].size() != 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Word lands in every PE whose tag matches
    task automatic record_word(input gb_word_t w);
        int prod;
        int kidx;
        kidx = int'(w.kind);
        for (int p = 0; p < NUM_PE; p++) begin
            if (model_tags[p] == int'(w.tag)) begin
                // Operand view for ifmap and weight, psum view otherwise
                if (w.kind == KIND_PSUM) begin
                    op_q[p][kidx].push_back(int'(w.payload.psum));
                end else begin
                    op_q[p][kidx].push_back(int'(w.payload.op.val));
                end
            end
            if (op_q[p][0].size() != 0 && op_q[p][1].size() != 0 &&
                op_q[p][2].size() != 0) begin
                // Old psum plus product, int arithmetic wraps at 32 bits
                prod = op_q[p][0].pop_front() * op_q[p][1].pop_front();
                exp_q[p].push_back(op_q[p][2].pop_front() + prod);
            end
        end
    endtask

    task automatic check_result(input psum_result_t r);
        int idx;
        idx = int'(r.pe_idx);
        n_results++;
        if (exp_q[idx].size() == 0) begin
            errors++;
            $display("Unexpected result from PE %0d at time %0t, none was pending", idx, $time);
        end else begin
            check_value(r.psum, exp_q[idx].pop_front(), $sformatf("PE %0d result", idx));
        end
    endtask

    // Mid-cycle sampling, inputs move only after the rising edge
    always @(negedge clk) begin
        if (rstn) begin
            // Transfer uses the tags from before a same-edge flush
            if (gb_valid && gb_ready) begin
                record_word(gb_word);
            end
            if (res_valid && res_ready) begin
                check_result(res_word);
            end
            if (flush) begin
                for (int p = 0; p < NUM_PE; p++) begin
                    model_tags[p] = int'(cfg_tags[p]);
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYC_LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Results checked: %0d, errors: %0d", n_results, errors);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // One clock, handshake seen mid-cycle, then new result-side ready
    task automatic step_cycle(output bit took);
        @(negedge clk);
        took = gb_valid && gb_ready;
        @(posedge clk);
        #10;
        if (stall_left > 0) begin
            stall_left--;
            res_ready = 1'b0;
        end else if (rand_below(60) == 0) begin
            // Long back-pressure stretch
            stall_left = 20 + rand_below(20);
            res_ready  = 1'b0;
        end else begin
            res_ready = (rand_below(10) >= 3);
        end
    endtask

    task automatic pick_word(output gb_word_t w);
        int tag;
        int kind;
        int tries;
        tries = 0;
        do begin
            // Mostly live tags, some that hit no PE
            tag  = (rand_below(10) < 8) ? rand_below(4) : 4 + rand_below(4);
            kind = rand_below(3);
            tries++;
        end while (!word_safe(tag, kind) && tries < 32);
        if (!word_safe(tag, kind)) begin
            tag = 7;
        end
        w.kind         = op_kind_e'(kind);
        w.tag          = TAG_W'(tag);
        w.payload.psum = $random(seed);
    endtask

    task automatic send_word(input gb_word_t w);
        bit took;
        int gap;
        gap      = (rand_below(4) == 0) ? 1 + rand_below(3) : 0;
        gb_valid = 1'b0;
        repeat (gap) step_cycle(took);
        gb_valid = 1'b1;
        gb_word  = w;
        // Word held until taken
        do begin
            step_cycle(took);
        end while (!took);
        gb_valid = 1'b0;
    endtask

    // Wait until every complete operand set has come back
    task automatic drain();
        bit took;
        gb_valid = 1'b0;
        while (results_pending()) begin
            step_cycle(took);
        end
    endtask

    // Partial sets stay in the slots across the flush
    task automatic retag(input logic [NUM_PE-1:0][TAG_W-1:0] tags);
        bit took;
        drain();
        flush    = 1'b1;
        cfg_tags = tags;
        step_cycle(took);
        flush    = 1'b0;
    endtask

    initial begin
        logic [NUM_PE-1:0][TAG_W-1:0] tags;
        gb_word_t                     w;
        bit                           took;
        rstn       = 1'b0;
        flush      = 1'b0;
        cfg_tags   = '0;
        gb_valid   = 1'b0;
        gb_word    = '0;
        res_ready  = 1'b0;
        errors     = 0;
        n_results  = 0;
        cycles     = 0;
        stall_left = 0;
        for (int p = 0; p < NUM_PE; p++) begin
            model_tags[p] = 0;
        end
        repeat (4) @(posedge clk);
        #10;
        rstn = 1'b1;
        @(negedge clk);
        check_value(gb_ready, 1, "gb_ready after reset");
        check_value(res_valid, 0, "res_valid after reset");
        @(posedge clk);
        #10;
        // Phase 0 unicast, 1 forced multicast, then random retags
        for (int ph = 0; ph < PHASES; ph++) begin
            for (int p = 0; p < NUM_PE; p++) begin
                tags[p] = (ph == 0) ? TAG_W'(p) : TAG_W'(rand_below(4));
            end
            if (ph == 1) begin
                tags[2] = tags[0];
            end
            retag(tags);
            repeat (NUM_XFER / PHASES) begin
                pick_word(w);
                send_word(w);
            end
        end
        drain();
        // Tail window for stray results
        repeat (20) step_cycle(took);
        $display("Results checked: %0d, errors: %0d", n_results, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
